// File: sim.f
+incdir+hdl
hdl/glb_pkg.sv
hdl/glb_sram_array.sv
hdl/glb_sram_controller.sv
hdl/glb_bank.sv
sim/glb_bank_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the global buffer bank testbench with Verilator and runs it.
# The log goes to sim.log and the run counts as passed only when the
# testbench wrote its pass line there.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module glb_bank_tb \
    -f sim.f \
    -o glb_bank_sim \
    && ./obj_dir/glb_bank_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "SIMULATION PASSED" sim.log 2>/dev/null \
    && echo "run_sim: test run ok" \
    || { echo "run_sim: test run failed"; exit 1; }

// File: sim/glb_bank_tb.sv
// Testbench for one global buffer bank.
// Drives the data and config paths on the falling edge, keeps a shadow copy
// of the array and checks data_out and config_rd_data every rising edge
// with concurrent assertions. A watchdog bounds the run.
`timescale 1ns/1ps

`include "glb_config.svh"

module glb_bank_tb;

    import glb_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int DEPTH        = `GLB_SRAM_DEPTH;
    localparam int CFG_BITS     = `GLB_CONFIG_DATA_WIDTH;
    localparam int N_RAND       = 64;
    localparam int N_CFG        = 16;

    // fill, masked writes with read back, then three config loops of up to 7 cycles
    localparam int TEST_CYCLES  = RESET_CYCLES + DEPTH + 3 * N_RAND + 3 * 7 * N_CFG + 16;
    localparam int WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD + 2000;

    logic         clk;
    logic         reset;
    logic         ren;
    logic         wen;
    bank_addr_t   addr;
    bank_data_t   data_in;
    bank_data_t   data_in_bit_sel;
    bank_data_t   data_out;
    logic         config_en;
    logic         config_wr;
    logic         config_rd;
    bank_addr_t   config_addr;
    config_data_t config_wr_data;
    config_data_t config_rd_data;

    // shadow of the array contents
    bank_data_t   shadow [DEPTH];

    // expected outputs for the current cycle, updated at the falling edge
    bank_data_t   exp_data_out;
    config_data_t exp_cfg_out;
    logic         data_rd_due;
    logic         cfg_rd_due;

    // what the access driven this cycle will show after the next edge
    bank_data_t   next_data_out;
    config_data_t next_cfg_out;
    logic         next_data_rd;
    logic         next_cfg_rd;

    int           errors;
    int           data_reads;
    int           cfg_reads;
    integer       seed;
    bank_addr_t   wr_addrs [N_RAND];

    glb_bank dut (
        .clk             (clk),
        .reset           (reset),
        .ren             (ren),
        .wen             (wen),
        .addr            (addr),
        .data_in         (data_in),
        .data_in_bit_sel (data_in_bit_sel),
        .data_out        (data_out),
        .config_en       (config_en),
        .config_wr       (config_wr),
        .config_rd       (config_rd),
        .config_addr     (config_addr),
        .config_wr_data  (config_wr_data),
        .config_rd_data  (config_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // read results, one cycle after the strobe
    data_read_check: assert property (@(posedge clk) disable iff (reset)
        data_rd_due |-> data_out === exp_data_out)
    else begin
        errors = errors + 1;
        $display("FAILED data_out after read: expected %h, got %h",
                 exp_data_out, $sampled(data_out));
    end

    cfg_read_check: assert property (@(posedge clk) disable iff (reset)
        cfg_rd_due |-> config_rd_data === exp_cfg_out)
    else begin
        errors = errors + 1;
        $display("FAILED config_rd_data after read: expected %h, got %h",
                 exp_cfg_out, $sampled(config_rd_data));
    end

    // outputs hold their last read value, zero straight after reset
    data_hold_check: assert property (@(posedge clk) disable iff (reset)
        !data_rd_due |-> data_out === exp_data_out)
    else begin
        errors = errors + 1;
        $display("FAILED data_out hold: expected %h, got %h",
                 exp_data_out, $sampled(data_out));
    end

    cfg_hold_check: assert property (@(posedge clk) disable iff (reset)
        !cfg_rd_due |-> config_rd_data === exp_cfg_out)
    else begin
        errors = errors + 1;
        $display("FAILED config_rd_data hold: expected %h, got %h",
                 exp_cfg_out, $sampled(config_rd_data));
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: test sequence still running after %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic bank_data_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic bank_addr_t rand_addr();
        return bank_addr_t'($random(seed));
    endfunction

    // byte address of a word, upper selects the high config half
    function automatic bank_addr_t word_addr(input sram_addr_t idx, input logic upper);
        return {idx, upper, 2'b00};
    endfunction

    // every word differs, both halves depend on the whole index
    function automatic bank_data_t fill_word(input int idx);
        logic [31:0] a;
        a = idx;
        return {a * 32'h9e37_79b1, ~(a * 32'h85eb_ca6b)};
    endfunction

    // one cycle of stimulus, with the priority and merge rules applied to the shadow
    task automatic access(input logic r, input logic w, input bank_addr_t a,
                          input bank_data_t d, input bank_data_t m,
                          input logic ce, input logic cw, input logic cr,
                          input bank_addr_t ca, input config_data_t cd);
        sram_addr_t cidx;
        sram_addr_t didx;
        logic       upper;
        bank_data_t word;
        @(negedge clk);
        exp_data_out = next_data_out;
        exp_cfg_out  = next_cfg_out;
        data_rd_due  = next_data_rd;
        cfg_rd_due   = next_cfg_rd;
        next_data_rd = 1'b0;
        next_cfg_rd  = 1'b0;

        ren             = r;
        wen             = w;
        addr            = a;
        data_in         = d;
        data_in_bit_sel = m;
        config_en       = ce;
        config_wr       = cw;
        config_rd       = cr;
        config_addr     = ca;
        config_wr_data  = cd;

        cidx  = ca[`GLB_BANK_ADDR_WIDTH-1:`GLB_BANK_ADDR_BYTE_OFFSET];
        didx  = a[`GLB_BANK_ADDR_WIDTH-1:`GLB_BANK_ADDR_BYTE_OFFSET];
        upper = ca[`GLB_BANK_ADDR_BYTE_OFFSET-1];
        if (ce && cw) begin
            if (upper) begin
                shadow[cidx][`GLB_BANK_DATA_WIDTH-1 -: CFG_BITS] = cd;
            end else begin
                shadow[cidx][CFG_BITS-1:0] = cd;
            end
        end else if (ce && cr) begin
            word         = shadow[cidx];
            next_cfg_out = upper ? word[`GLB_BANK_DATA_WIDTH-1 -: CFG_BITS] : word[CFG_BITS-1:0];
            next_cfg_rd  = 1'b1;
            cfg_reads    = cfg_reads + 1;
        end else if (w) begin
            // a set mask bit takes the new bit, a clear one keeps the stored bit
            for (int b = 0; b < `GLB_BANK_DATA_WIDTH; b++) begin
                if (m[b]) begin
                    shadow[didx][b] = d[b];
                end
            end
        end else if (r) begin
            next_data_out = shadow[didx];
            next_data_rd  = 1'b1;
            data_reads    = data_reads + 1;
        end
    endtask

    task automatic idle();
        access(1'b0, 1'b0, '0, '0, '0, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic data_write(input bank_addr_t a, input bank_data_t d, input bank_data_t m);
        access(1'b0, 1'b1, a, d, m, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic data_read(input bank_addr_t a);
        access(1'b1, 1'b0, a, '0, '0, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic cfg_write(input bank_addr_t ca, input config_data_t cd);
        access(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b1, 1'b0, ca, cd);
    endtask

    task automatic cfg_read(input bank_addr_t ca);
        access(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b0, 1'b1, ca, '0);
    endtask

    initial begin
        sram_addr_t idx;
        bank_addr_t a;
        bank_addr_t ca;
        seed            = 86;
        errors          = 0;
        data_reads      = 0;
        cfg_reads       = 0;
        ren             = 1'b0;
        wen             = 1'b0;
        addr            = '0;
        data_in         = '0;
        data_in_bit_sel = '0;
        config_en       = 1'b0;
        config_wr       = 1'b0;
        config_rd       = 1'b0;
        config_addr     = '0;
        config_wr_data  = '0;
        exp_data_out    = '0;
        exp_cfg_out     = '0;
        data_rd_due     = 1'b0;
        cfg_rd_due      = 1'b0;
        next_data_out   = '0;
        next_cfg_out    = '0;
        next_data_rd    = 1'b0;
        next_cfg_rd     = 1'b0;

        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // outputs read as zero before any read
        repeat (3) idle();

        // known contents everywhere so every later read is defined
        for (int i = 0; i < DEPTH; i++) begin
            data_write(word_addr(sram_addr_t'(i), 1'b0), fill_word(i), '1);
        end

        // masked writes, read back in back-to-back pairs
        for (int k = 0; k < N_RAND; k++) begin
            wr_addrs[k] = rand_addr();
            data_write(wr_addrs[k], rand_word(), rand_word());
        end
        for (int k = 0; k < N_RAND; k += 2) begin
            data_read(wr_addrs[k]);
            data_read(wr_addrs[k + 1]);
            idle();
        end

        // config writes to both halves, then one half alone
        for (int k = 0; k < N_CFG; k++) begin
            idx = sram_addr_t'($random(seed));
            cfg_write(word_addr(idx, 1'b0), config_data_t'($random(seed)));
            cfg_write(word_addr(idx, 1'b1), config_data_t'($random(seed)));
            data_read(word_addr(idx, 1'b0));
            idx = ~idx;
            cfg_write(word_addr(idx, k[0]), config_data_t'($random(seed)));
            data_read(word_addr(idx, 1'b0));
            idle();
        end

        // config reads of both halves after a full data write
        for (int k = 0; k < N_CFG; k++) begin
            idx = sram_addr_t'($random(seed));
            data_write(word_addr(idx, 1'b0), rand_word(), '1);
            cfg_read(word_addr(idx, 1'b0));
            cfg_read(word_addr(idx, 1'b1));
            idle();
        end

        // data strobes lose against config accesses in the same cycle
        for (int k = 0; k < N_CFG; k++) begin
            idx = sram_addr_t'($random(seed));
            a   = word_addr(idx, 1'b0);
            ca  = word_addr(~idx, k[0]);
            access(1'b0, 1'b1, a, rand_word(), '1, 1'b1, 1'b1, 1'b0, ca,
                   config_data_t'($random(seed)));
            data_read(a);
            data_read(ca);
            access(1'b0, 1'b1, a, rand_word(), '1, 1'b1, 1'b0, 1'b1, ca, '0);
            data_read(a);
            access(1'b1, 1'b0, ca, '0, '0, 1'b1, 1'b0, 1'b1, a, '0);
            idle();
        end

        // let the last read reach its check
        idle();
        idle();

        $display("summary: %0d errors, %0d data reads and %0d config reads checked",
                 errors, data_reads, cfg_reads);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/glb_bank.sv
// One global buffer bank. The SRAM controller arbitrates the data and
// config paths onto a single-port array. Both read paths return data
// exactly one cycle after the strobe.
`timescale 1ns/1ps

module glb_bank (
    input  logic                  clk,
    input  logic                  reset,

    // wide data path
    input  logic                  ren,
    input  logic                  wen,
    input  glb_pkg::bank_addr_t   addr,
    input  glb_pkg::bank_data_t   data_in,
    input  glb_pkg::bank_data_t   data_in_bit_sel,
    output glb_pkg::bank_data_t   data_out,

    // narrow config path
    input  logic                  config_en,
    input  logic                  config_wr,
    input  logic                  config_rd,
    input  glb_pkg::bank_addr_t   config_addr,
    input  glb_pkg::config_data_t config_wr_data,
    output glb_pkg::config_data_t config_rd_data
);

    import glb_pkg::*;

    // controller to array
    logic       sram_cen;
    logic       sram_wen;
    sram_addr_t sram_addr;
    bank_data_t sram_data;
    bank_data_t sram_bit_sel;
    bank_data_t sram_rd_data;

    glb_sram_controller u_sram_controller (
        .clk             (clk),
        .reset           (reset),
        .ren             (ren),
        .wen             (wen),
        .addr            (addr),
        .data_in         (data_in),
        .data_in_bit_sel (data_in_bit_sel),
        .data_out        (data_out),
        .config_en       (config_en),
        .config_wr       (config_wr),
        .config_rd       (config_rd),
        .config_addr     (config_addr),
        .config_wr_data  (config_wr_data),
        .config_rd_data  (config_rd_data),
        .sram_cen        (sram_cen),
        .sram_wen        (sram_wen),
        .sram_addr       (sram_addr),
        .sram_data       (sram_data),
        .sram_bit_sel    (sram_bit_sel),
        .sram_rd_data    (sram_rd_data)
    );

    glb_sram_array u_sram_array (
        .clk          (clk),
        .sram_cen     (sram_cen),
        .sram_wen     (sram_wen),
        .sram_addr    (sram_addr),
        .sram_data    (sram_data),
        .sram_bit_sel (sram_bit_sel),
        .sram_rd_data (sram_rd_data)
    );

endmodule

// File: hdl/glb_sram_controller.sv
// Arbitrates the config path and the wide data path onto one SRAM port.
// Config writes win, then config reads, then data strobes. Read data from
// the array comes back one cycle later and each output holds until its next read.
`timescale 1ns/1ps

`include "glb_config.svh"

module glb_sram_controller (
    input  logic                 clk,
    input  logic                 reset,

    // wide data path
    input  logic                 ren,
    input  logic                 wen,
    input  glb_pkg::bank_addr_t  addr,
    input  glb_pkg::bank_data_t  data_in,
    input  glb_pkg::bank_data_t  data_in_bit_sel,
    output glb_pkg::bank_data_t  data_out,

    // narrow config path
    input  logic                 config_en,
    input  logic                 config_wr,
    input  logic                 config_rd,
    input  glb_pkg::bank_addr_t  config_addr,
    input  glb_pkg::config_data_t config_wr_data,
    output glb_pkg::config_data_t config_rd_data,

    // SRAM port
    output logic                 sram_cen,
    output logic                 sram_wen,
    output glb_pkg::sram_addr_t  sram_addr,
    output glb_pkg::bank_data_t  sram_data,
    output glb_pkg::bank_data_t  sram_bit_sel,
    input  glb_pkg::bank_data_t  sram_rd_data
);

    import glb_pkg::*;

    logic         cfg_wr;
    logic         cfg_rd;
    logic         data_rd;
    logic         cfg_half;
    sram_addr_t   cfg_word_addr;
    sram_addr_t   data_word_addr;
    bank_data_t   cfg_wr_word;
    bank_data_t   cfg_wr_mask;

    logic         data_rd_pending;
    logic         cfg_rd_pending;
    logic         cfg_half_q;
    bank_data_t   data_out_q;
    config_data_t config_rd_data_q;
    config_data_t cfg_rd_half;

    assign cfg_wr = config_en & config_wr;
    assign cfg_rd = config_en & config_rd & ~config_wr;
    // a data access only reaches the array when no config access is present
    assign data_rd = ~(config_en & (config_wr | config_rd)) & ren & ~wen;

    // bit 2 of the byte address picks the upper half
    assign cfg_half = config_addr[`GLB_BANK_ADDR_BYTE_OFFSET-1];

    assign cfg_word_addr  = config_addr[`GLB_BANK_ADDR_WIDTH-1:`GLB_BANK_ADDR_BYTE_OFFSET];
    assign data_word_addr = addr[`GLB_BANK_ADDR_WIDTH-1:`GLB_BANK_ADDR_BYTE_OFFSET];

    // place the config word in its half and mask off the other half
    always_comb begin
        if (cfg_half) begin
            cfg_wr_word = {config_wr_data[`GLB_BANK_DATA_WIDTH-`GLB_CONFIG_DATA_WIDTH-1:0],
                           {`GLB_CONFIG_DATA_WIDTH{1'b0}}};
            cfg_wr_mask = {{(`GLB_BANK_DATA_WIDTH-`GLB_CONFIG_DATA_WIDTH){1'b1}},
                           {`GLB_CONFIG_DATA_WIDTH{1'b0}}};
        end else begin
            cfg_wr_word = {{(`GLB_BANK_DATA_WIDTH-`GLB_CONFIG_DATA_WIDTH){1'b0}},
                           config_wr_data};
            cfg_wr_mask = {{(`GLB_BANK_DATA_WIDTH-`GLB_CONFIG_DATA_WIDTH){1'b0}},
                           {`GLB_CONFIG_DATA_WIDTH{1'b1}}};
        end
    end

    // priority mux onto the SRAM port
    always_comb begin
        if (cfg_wr) begin
            sram_cen     = 1'b1;
            sram_wen     = 1'b1;
            sram_addr    = cfg_word_addr;
            sram_data    = cfg_wr_word;
            sram_bit_sel = cfg_wr_mask;
        end else if (cfg_rd) begin
            sram_cen     = 1'b1;
            sram_wen     = 1'b0;
            sram_addr    = cfg_word_addr;
            sram_data    = '0;
            sram_bit_sel = '0;
        end else begin
            // wen wins when both strobes are set
            sram_cen     = ren | wen;
            sram_wen     = wen;
            sram_addr    = data_word_addr;
            sram_data    = data_in;
            sram_bit_sel = data_in_bit_sel;
        end
    end

    // pending flags line up with the array's registered read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_rd_pending  <= 1'b0;
            cfg_rd_pending   <= 1'b0;
            cfg_half_q       <= 1'b0;
            data_out_q       <= '0;
            config_rd_data_q <= '0;
        end else begin
            data_rd_pending  <= data_rd;
            cfg_rd_pending   <= cfg_rd;
            if (cfg_rd) begin
                cfg_half_q <= cfg_half;
            end
            data_out_q       <= data_out;
            config_rd_data_q <= config_rd_data;
        end
    end

    // half picked with the registered select, matching the delayed word
    assign cfg_rd_half = cfg_half_q ?
        sram_rd_data[`GLB_BANK_DATA_WIDTH-1 -: `GLB_CONFIG_DATA_WIDTH] :
        sram_rd_data[`GLB_CONFIG_DATA_WIDTH-1:0];

    // fresh data right after a read, otherwise the held value
    assign data_out       = data_rd_pending ? sram_rd_data : data_out_q;
    assign config_rd_data = cfg_rd_pending ? cfg_rd_half : config_rd_data_q;

endmodule

// File: hdl/glb_sram_array.sv
// Behavioural single-port SRAM for one bank.
// Writes merge under a per-bit mask when cen and wen are high. A read with
// cen high and wen low shows the word on sram_rd_data after the clock edge.
`timescale 1ns/1ps

`include "glb_config.svh"

module glb_sram_array (
    input  logic                clk,
    input  logic                sram_cen,
    input  logic                sram_wen,
    input  glb_pkg::sram_addr_t sram_addr,
    input  glb_pkg::bank_data_t sram_data,
    input  glb_pkg::bank_data_t sram_bit_sel,
    output glb_pkg::bank_data_t sram_rd_data
);

    import glb_pkg::*;

    // storage, no reset on the contents
    bank_data_t mem [`GLB_SRAM_DEPTH];

    bank_data_t cur_word;
    bank_data_t merged_word;
    logic       do_write;
    logic       do_read;

    assign do_write = sram_cen & sram_wen;
    assign do_read  = sram_cen & ~sram_wen;

    assign cur_word = mem[sram_addr];

    // keep old bits where the mask is 0
    assign merged_word = (cur_word & ~sram_bit_sel) | (sram_data & sram_bit_sel);

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[sram_addr] <= merged_word;
        end
    end

    // read register holds its value while the array is idle or writing
    always_ff @(posedge clk) begin
        if (do_read) begin
            sram_rd_data <= cur_word;
        end
    end

endmodule

// File: hdl/glb_pkg.sv
// Types shared by the bank RTL and its testbench.
// Modules import it inside the body and use scoped names in their port lists.
package glb_pkg;

`include "glb_config.svh"

    // full bank word, used for both data and bit-select masks
    typedef logic [`GLB_BANK_DATA_WIDTH-1:0] bank_data_t;

    // word on the narrow config path
    typedef logic [`GLB_CONFIG_DATA_WIDTH-1:0] config_data_t;

    // byte address as seen by the host and the config path
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // word index into the SRAM, byte offset dropped
    typedef logic [`GLB_BANK_ADDR_WIDTH-`GLB_BANK_ADDR_BYTE_OFFSET-1:0] sram_addr_t;

endpackage

// File: hdl/glb_config.svh
// Size settings for one global buffer bank.
// Included by the package and by any RTL file that needs the raw widths.
`ifndef GLB_CONFIG_SVH
`define GLB_CONFIG_SVH

// width of one bank word, also the width of its bit-select mask
`define GLB_BANK_DATA_WIDTH 64

// config path word width
// has to be at least half the bank word so two halves cover the word
`define GLB_CONFIG_DATA_WIDTH 32

// byte address width of the bank, 4 KB
`define GLB_BANK_ADDR_WIDTH 12

// byte-address bits below the word index
// the top one of these picks the config half
`define GLB_BANK_ADDR_BYTE_OFFSET 3

// number of words held by the bank
`define GLB_SRAM_DEPTH (1 << (`GLB_BANK_ADDR_WIDTH - `GLB_BANK_ADDR_BYTE_OFFSET))

`endif
